// File: verilog.f
source/stdout_pkg.sv
source/stdout_capture.sv
source/stdout_buffer.sv
source/stdout_regs.sv
source/stdout_top.sv
tests/tb_stdout_top.sv

// File: Bender.yml
package:
  name: stdout_capture

sources:
  - source/stdout_pkg.sv
  - source/stdout_capture.sv
  - source/stdout_buffer.sv
  - source/stdout_regs.sv
  - source/stdout_top.sv
  - target: test
    files:
      - tests/tb_stdout_top.sv

// File: tests/tb_stdout_top.sv
module tb_stdout_top;

  timeunit 1ns;
  timeprecision 100ps;

  import stdout_pkg::*;

  localparam int unsigned buf_bytes  = 1024;
  localparam int unsigned region     = buf_bytes / 4;
  localparam int unsigned core_words = region / 4;
  localparam int unsigned threshold  = region / 16 * 15;
  localparam int          clk_period = 100;
  localparam int          max_wait   = 50;

  logic                  ref_clk_i;
  logic                  rst_ni;
  logic                  char_psel;
  logic                  char_penable;
  logic                  char_pwrite;
  logic [apb_addr_w-1:0] char_paddr;
  logic [apb_data_w-1:0] char_pwdata;
  logic                  char_pready;
  logic                  char_pslverr;
  logic                  host_psel;
  logic                  host_penable;
  logic                  host_pwrite;
  logic [apb_addr_w-1:0] host_paddr;
  logic [apb_data_w-1:0] host_pwdata;
  logic [apb_data_w-1:0] host_prdata;
  logic                  host_pready;
  logic                  host_pslverr;
  logic                  stdout_wait;

  // Reference model of the captured text.
  logic [7:0]  ref_mem [num_cores][region];
  int unsigned ref_cnt [num_cores];
  int          errors;
  int          checks;
  integer      seed;

  stdout_top #(
    .buf_bytes (buf_bytes)
  ) stdout_top_i (
    .ref_clk_i    (ref_clk_i),
    .rst_ni       (rst_ni),
    .char_psel    (char_psel),
    .char_penable (char_penable),
    .char_pwrite  (char_pwrite),
    .char_paddr   (char_paddr),
    .char_pwdata  (char_pwdata),
    .char_pready  (char_pready),
    .char_pslverr (char_pslverr),
    .host_psel    (host_psel),
    .host_penable (host_penable),
    .host_pwrite  (host_pwrite),
    .host_paddr   (host_paddr),
    .host_pwdata  (host_pwdata),
    .host_prdata  (host_prdata),
    .host_pready  (host_pready),
    .host_pslverr (host_pslverr),
    .stdout_wait  (stdout_wait)
  );

  initial begin
    ref_clk_i = 1'b0;
    forever #(clk_period / 2) ref_clk_i = ~ref_clk_i;
  end

  // About 1500 transfers of up to 4 cycles each, plus margin.
  initial begin
    #(1500 * 4 * clk_period + 100000);
    $display("Watchdog expired at %0t ns before the tests finished", $time);
    $display("Checks failed");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Reference functions.
  // --------------------------------------------------------------------------

  function automatic logic [31:0] expected_word(input int unsigned core, input int unsigned word);
    logic [31:0] w;
    w = '0;
    for (int b = 0; b < 4; b++) begin
      if (word * 4 + b < ref_cnt[core]) begin
        w[8*b +: 8] = ref_mem[core][word * 4 + b];
      end
    end
    return w;
  endfunction

  // Lanes written since the last flush.
  function automatic logic [31:0] lane_mask(input int unsigned core, input int unsigned word);
    logic [31:0] m;
    m = '0;
    for (int b = 0; b < 4; b++) begin
      if (word * 4 + b < ref_cnt[core]) begin
        m[8*b +: 8] = 8'hff;
      end
    end
    return m;
  endfunction

  // --------------------------------------------------------------------------
  // Bus tasks and checks.
  // --------------------------------------------------------------------------

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %0t ns %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
    end
  endtask

  task automatic char_transfer(input logic write, input logic [7:0] slot, input logic [7:0] ch,
                               output logic err, output int waits);
    int cycles;
    @(posedge ref_clk_i);
    #10;
    char_psel    = 1'b1;
    char_penable = 1'b0;
    char_pwrite  = write;
    char_paddr   = {4'h0, slot};
    char_pwdata  = {24'h0, ch};
    @(posedge ref_clk_i);
    #10;
    char_penable = 1'b1;
    cycles       = 0;
    @(negedge ref_clk_i);
    while (!char_pready && cycles < max_wait) begin
      cycles++;
      @(negedge ref_clk_i);
    end
    if (!char_pready) begin
      errors++;
      $display("Character transfer to slot 0x%02h never completed at %0t ns", slot, $time);
    end
    err   = char_pslverr;
    waits = cycles;
    @(posedge ref_clk_i);
    #10;
    char_psel    = 1'b0;
    char_penable = 1'b0;
  endtask

  task automatic host_transfer(input logic write, input logic [apb_addr_w-1:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
    int cycles;
    @(posedge ref_clk_i);
    #10;
    host_psel    = 1'b1;
    host_penable = 1'b0;
    host_pwrite  = write;
    host_paddr   = addr;
    host_pwdata  = wdata;
    @(posedge ref_clk_i);
    #10;
    host_penable = 1'b1;
    cycles       = 0;
    @(negedge ref_clk_i);
    while (!host_pready && cycles < max_wait) begin
      cycles++;
      @(negedge ref_clk_i);
    end
    if (!host_pready) begin
      errors++;
      $display("Host transfer to 0x%03h never completed at %0t ns", addr, $time);
    end
    rdata = host_prdata;
    err   = host_pslverr;
    @(posedge ref_clk_i);
    #10;
    host_psel    = 1'b0;
    host_penable = 1'b0;
  endtask

  task automatic check_counts();
    logic [31:0] rdata;
    logic        err;
    for (int c = 0; c < num_cores; c++) begin
      host_transfer(1'b0, reg_count_base + 4 * c, '0, rdata, err);
      check_value($sformatf("COUNT%0d", c), ref_cnt[c], rdata);
      check_value("host_pslverr", 0, err);
    end
  endtask

  task automatic check_window(input int unsigned core);
    logic [31:0] rdata;
    logic [31:0] mask;
    logic        err;
    int unsigned idx;
    for (int unsigned w = 0; w < (ref_cnt[core] + 3) / 4; w++) begin
      idx  = core * core_words + w;
      mask = lane_mask(core, w);
      host_transfer(1'b0, reg_window_base + 4 * idx, '0, rdata, err);
      check_value($sformatf("window[%0d]", idx), expected_word(core, w), rdata & mask);
      check_value("host_pslverr", 0, err);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, errors - err_before);
    end
  endtask

  // --------------------------------------------------------------------------
  // Test sequence.
  // --------------------------------------------------------------------------

  initial begin : main
    logic [31:0] rdata;
    logic [7:0]  ch;
    logic        err;
    logic        herr;
    int          waits;
    int          err_before;
    seed         = 55542;
    errors       = 0;
    checks       = 0;
    rst_ni       = 1'b0;
    char_psel    = 1'b0;
    char_penable = 1'b0;
    char_pwrite  = 1'b0;
    char_paddr   = '0;
    char_pwdata  = '0;
    host_psel    = 1'b0;
    host_penable = 1'b0;
    host_pwrite  = 1'b0;
    host_paddr   = '0;
    host_pwdata  = '0;
    for (int c = 0; c < num_cores; c++) begin
      ref_cnt[c] = 0;
    end
    repeat (10) @(posedge ref_clk_i);
    #10;
    rst_ni = 1'b1;

    err_before = errors;
    host_transfer(1'b0, reg_status, '0, rdata, herr);
    check_value("STATUS", 0, rdata);
    host_transfer(1'b0, reg_ctrl, '0, rdata, herr);
    check_value("CTRL", 0, rdata);
    check_counts();
    check_value("stdout_wait", 0, stdout_wait);
    report_test("1 reset values", err_before);

    err_before = errors;
    host_transfer(1'b1, reg_ctrl, 32'h1, rdata, herr);
    for (int i = 0; i < 40; i++) begin
      for (int c = 0; c < num_cores; c++) begin
        ch = $random(seed);
        char_transfer(1'b1, slot_stride * c, ch, err, waits);
        check_value("char_pslverr", 0, err);
        check_value("char wait states", 0, waits);
        ref_mem[c][ref_cnt[c]] = ch;
        ref_cnt[c]++;
      end
    end
    check_counts();
    for (int c = 0; c < num_cores; c++) begin
      check_window(c);
    end
    report_test("2 interleaved capture", err_before);

    err_before = errors;
    char_transfer(1'b1, 8'h10, 8'h41, err, waits);
    check_value("char_pslverr", 1, err);
    char_transfer(1'b0, 8'h00, 8'h00, err, waits);
    check_value("char_pslverr", 1, err);
    check_counts();
    report_test("3 bad slot and read", err_before);

    err_before = errors;
    host_transfer(1'b1, reg_ctrl, 32'h3, rdata, herr);
    for (int c = 0; c < num_cores; c++) begin
      ref_cnt[c] = 0;
    end
    for (int i = 0; i < threshold; i++) begin
      ch = $random(seed);
      char_transfer(1'b1, slot_stride * 2, ch, err, waits);
      check_value("char_pslverr", 0, err);
      ref_mem[2][ref_cnt[2]] = ch;
      ref_cnt[2]++;
    end
    host_transfer(1'b0, reg_status, '0, rdata, herr);
    check_value("STATUS", 1, rdata);
    check_value("stdout_wait", 1, stdout_wait);
    ch = $random(seed);
    fork
      char_transfer(1'b1, slot_stride, ch, err, waits);
      begin
        // The stall shows once the access phase has started.
        @(posedge char_penable);
        repeat (4) begin
          @(negedge ref_clk_i);
          check_value("char_pready", 0, char_pready);
        end
        host_transfer(1'b1, reg_ctrl, 32'h3, rdata, herr);
      end
    join
    check_value("char_pslverr", 0, err);
    if (waits == 0) begin
      errors++;
      $display("Character write to core 1 did not stall while the buffer was full");
    end
    for (int c = 0; c < num_cores; c++) begin
      ref_cnt[c] = 0;
    end
    ref_mem[1][0] = ch;
    ref_cnt[1]    = 1;
    check_counts();
    check_window(1);
    check_value("stdout_wait", 0, stdout_wait);
    report_test("4 full region stall and flush", err_before);

    err_before = errors;
    host_transfer(1'b1, reg_ctrl, 32'h0, rdata, herr);
    ref_cnt[1] = 0;
    for (int i = 0; i < 10; i++) begin
      ch = $random(seed);
      char_transfer(1'b1, slot_stride * (i % num_cores), ch, err, waits);
      check_value("char_pslverr", 0, err);
      check_value("char wait states", 0, waits);
      check_value("stdout_wait", 0, stdout_wait);
    end
    check_counts();
    report_test("5 capture disabled", err_before);

    $display("Summary: 5 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: source/stdout_top.sv
module stdout_top #(
  parameter int unsigned buf_bytes = 1024
) (
  input  logic                               ref_clk_i,
  input  logic                               rst_ni,
  // Character bus from the cores.
  input  logic                               char_psel,
  input  logic                               char_penable,
  input  logic                               char_pwrite,
  input  logic [stdout_pkg::apb_addr_w-1:0]  char_paddr,
  input  logic [stdout_pkg::apb_data_w-1:0]  char_pwdata,
  output logic                               char_pready,
  output logic                               char_pslverr,
  // Host register bus.
  input  logic                               host_psel,
  input  logic                               host_penable,
  input  logic                               host_pwrite,
  input  logic [stdout_pkg::apb_addr_w-1:0]  host_paddr,
  input  logic [stdout_pkg::apb_data_w-1:0]  host_pwdata,
  output logic [stdout_pkg::apb_data_w-1:0]  host_prdata,
  output logic                               host_pready,
  output logic                               host_pslverr,
  output logic                               stdout_wait
);

  import stdout_pkg::*;

  localparam int unsigned addr_w = $clog2(buf_bytes / 4);
  localparam int unsigned cnt_w  = $clog2(buf_bytes / 4) + 1;

  logic                    cap_en;
  logic                    flush_pulse;
  logic                    wr_en;
  logic [addr_w-1:0]       wr_addr;
  logic [apb_data_w/8-1:0] wr_strb;
  logic [apb_data_w-1:0]   wr_data;
  logic                    rd_en;
  logic [addr_w-1:0]       rd_addr;
  logic [apb_data_w-1:0]   rd_data;
  logic [cnt_w-1:0]        count0;
  logic [cnt_w-1:0]        count1;
  logic [cnt_w-1:0]        count2;
  logic [cnt_w-1:0]        count3;

  stdout_capture #(
    .buf_bytes (buf_bytes)
  ) stdout_capture_i (
    .ref_clk_i    (ref_clk_i),
    .rst_ni       (rst_ni),
    .char_psel    (char_psel),
    .char_penable (char_penable),
    .char_pwrite  (char_pwrite),
    .char_paddr   (char_paddr),
    .char_pwdata  (char_pwdata),
    .cap_en       (cap_en),
    .flush_pulse  (flush_pulse),
    .char_pready  (char_pready),
    .char_pslverr (char_pslverr),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_strb      (wr_strb),
    .wr_data      (wr_data),
    .count0       (count0),
    .count1       (count1),
    .count2       (count2),
    .count3       (count3),
    .wait_flag    (stdout_wait)
  );

  stdout_buffer #(
    .buf_bytes (buf_bytes)
  ) stdout_buffer_i (
    .ref_clk_i (ref_clk_i),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_strb   (wr_strb),
    .wr_data   (wr_data),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  stdout_regs #(
    .buf_bytes (buf_bytes)
  ) stdout_regs_i (
    .ref_clk_i    (ref_clk_i),
    .rst_ni       (rst_ni),
    .host_psel    (host_psel),
    .host_penable (host_penable),
    .host_pwrite  (host_pwrite),
    .host_paddr   (host_paddr),
    .host_pwdata  (host_pwdata),
    .count0       (count0),
    .count1       (count1),
    .count2       (count2),
    .count3       (count3),
    .wait_flag    (stdout_wait),
    .rd_data      (rd_data),
    .host_prdata  (host_prdata),
    .host_pready  (host_pready),
    .host_pslverr (host_pslverr),
    .cap_en       (cap_en),
    .flush_pulse  (flush_pulse),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr)
  );

endmodule

// File: source/stdout_regs.sv
module stdout_regs #(
  parameter  int unsigned buf_bytes = 1024,
  localparam int unsigned addr_w    = $clog2(buf_bytes / 4),
  localparam int unsigned cnt_w     = $clog2(buf_bytes / 4) + 1
) (
  input  logic                               ref_clk_i,
  input  logic                               rst_ni,
  input  logic                               host_psel,
  input  logic                               host_penable,
  input  logic                               host_pwrite,
  input  logic [stdout_pkg::apb_addr_w-1:0]  host_paddr,
  input  logic [stdout_pkg::apb_data_w-1:0]  host_pwdata,
  input  logic [cnt_w-1:0]                   count0,
  input  logic [cnt_w-1:0]                   count1,
  input  logic [cnt_w-1:0]                   count2,
  input  logic [cnt_w-1:0]                   count3,
  input  logic                               wait_flag,
  input  logic [stdout_pkg::apb_data_w-1:0]  rd_data,
  output logic [stdout_pkg::apb_data_w-1:0]  host_prdata,
  output logic                               host_pready,
  output logic                               host_pslverr,
  output logic                               cap_en,
  output logic                               flush_pulse,
  output logic                               rd_en,
  output logic [addr_w-1:0]                  rd_addr
);

  import stdout_pkg::*;

  logic                  access;
  logic                  hit_ctrl;
  logic                  win_rd;
  logic                  addr_ok;
  logic                  win_pend_q;
  logic [apb_addr_w-1:0] win_off;

  // ---------------------------------------------------------------------------
  // Address decode.
  // ---------------------------------------------------------------------------

  assign access   = host_psel & host_penable;
  assign hit_ctrl = (host_paddr == reg_ctrl);
  assign win_rd   = !host_pwrite && (host_paddr >= reg_window_base) &&
                    (host_paddr < reg_window_base + buf_bytes);
  assign win_off  = host_paddr - reg_window_base;

  // ---------------------------------------------------------------------------
  // Control register.
  // ---------------------------------------------------------------------------

  always_ff @(posedge ref_clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cap_en <= 1'b0;
    end else if (access && host_pwrite && hit_ctrl) begin
      cap_en <= host_pwdata[ctrl_en_bit];
    end
  end

  // Register writes complete in one cycle, so this is a single pulse.
  assign flush_pulse = access & host_pwrite & hit_ctrl & host_pwdata[ctrl_flush_bit];

  // ---------------------------------------------------------------------------
  // Buffer window.
  // ---------------------------------------------------------------------------

  // Read issued in the first access cycle, data returned in the second.
  assign rd_en   = access & win_rd & ~win_pend_q;
  assign rd_addr = addr_w'(win_off >> 2);

  always_ff @(posedge ref_clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      win_pend_q <= 1'b0;
    end else begin
      win_pend_q <= rd_en;
    end
  end

  // ---------------------------------------------------------------------------
  // Read data and response.
  // ---------------------------------------------------------------------------

  always_comb begin
    host_prdata = '0;
    addr_ok     = 1'b1;
    if (win_rd) begin
      host_prdata = rd_data;
    end else begin
      case (host_paddr)
        reg_ctrl:           host_prdata[ctrl_en_bit] = cap_en;
        reg_status: begin
          host_prdata[0] = wait_flag;
          addr_ok        = !host_pwrite;
        end
        reg_count_base: begin
          host_prdata[cnt_w-1:0] = count0;
          addr_ok                = !host_pwrite;
        end
        reg_count_base + 4: begin
          host_prdata[cnt_w-1:0] = count1;
          addr_ok                = !host_pwrite;
        end
        reg_count_base + 8: begin
          host_prdata[cnt_w-1:0] = count2;
          addr_ok                = !host_pwrite;
        end
        reg_count_base + 12: begin
          host_prdata[cnt_w-1:0] = count3;
          addr_ok                = !host_pwrite;
        end
        default:            addr_ok = 1'b0;
      endcase
    end
  end

  assign host_pready  = access & (~win_rd | win_pend_q);
  assign host_pslverr = host_pready & ~addr_ok;

endmodule

// File: source/stdout_buffer.sv
module stdout_buffer #(
  parameter  int unsigned buf_bytes = 1024,
  localparam int unsigned addr_w    = $clog2(buf_bytes / 4)
) (
  input  logic                                 ref_clk_i,
  input  logic                                 wr_en,
  input  logic [addr_w-1:0]                    wr_addr,
  input  logic [stdout_pkg::apb_data_w/8-1:0]  wr_strb,
  input  logic [stdout_pkg::apb_data_w-1:0]    wr_data,
  input  logic                                 rd_en,
  input  logic [addr_w-1:0]                    rd_addr,
  output logic [stdout_pkg::apb_data_w-1:0]    rd_data
);

  import stdout_pkg::*;

  localparam int unsigned num_words = buf_bytes / 4;
  localparam int unsigned num_lanes = apb_data_w / 8;

  logic [apb_data_w-1:0] mem_q [num_words];

  // Write port, one enable per byte lane.
  always_ff @(posedge ref_clk_i) begin
    if (wr_en) begin
      for (int b = 0; b < num_lanes; b++) begin
        if (wr_strb[b]) begin
          mem_q[wr_addr][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
    end
  end

  // Registered read port.
  // Data is valid the cycle after rd_en.
  always_ff @(posedge ref_clk_i) begin
    if (rd_en) begin
      rd_data <= mem_q[rd_addr];
    end
  end

endmodule

// File: source/stdout_capture.sv
module stdout_capture #(
  parameter  int unsigned buf_bytes = 1024,
  localparam int unsigned addr_w    = $clog2(buf_bytes / 4),
  localparam int unsigned cnt_w     = $clog2(buf_bytes / 4) + 1
) (
  input  logic                                 ref_clk_i,
  input  logic                                 rst_ni,
  input  logic                                 char_psel,
  input  logic                                 char_penable,
  input  logic                                 char_pwrite,
  input  logic [stdout_pkg::apb_addr_w-1:0]    char_paddr,
  input  logic [stdout_pkg::apb_data_w-1:0]    char_pwdata,
  input  logic                                 cap_en,
  input  logic                                 flush_pulse,
  output logic                                 char_pready,
  output logic                                 char_pslverr,
  output logic                                 wr_en,
  output logic [addr_w-1:0]                    wr_addr,
  output logic [stdout_pkg::apb_data_w/8-1:0]  wr_strb,
  output logic [stdout_pkg::apb_data_w-1:0]    wr_data,
  output logic [cnt_w-1:0]                     count0,
  output logic [cnt_w-1:0]                     count1,
  output logic [cnt_w-1:0]                     count2,
  output logic [cnt_w-1:0]                     count3,
  output logic                                 wait_flag
);

  import stdout_pkg::*;

  localparam int unsigned region    = buf_bytes / 4;
  localparam int unsigned threshold = region / 16 * 15;
  localparam int unsigned num_lanes = apb_data_w / 8;

  logic                  access;
  logic [7:0]            slot;
  logic [7:0]            slot_num;
  logic                  slot_ok;
  logic [core_sel_w-1:0] core_idx;
  logic [cnt_w-1:0]      count_q [num_cores];
  logic [cnt_w-1:0]      cur_count;
  logic                  over_thr;

  // ---------------------------------------------------------------------------
  // Slot decode and APB response.
  // ---------------------------------------------------------------------------

  assign slot     = char_paddr[7:0];
  assign slot_num = slot / slot_stride;
  // Only exact slot addresses of existing cores are accepted.
  assign slot_ok  = ((slot % slot_stride) == 8'd0) && (slot_num < num_cores);
  assign core_idx = slot_num[core_sel_w-1:0];

  assign access       = char_psel & char_penable;
  // Back-pressure while any region is nearly full.
  assign char_pready  = access & ~wait_flag;
  assign char_pslverr = char_pready & (~char_pwrite | ~slot_ok);

  // ---------------------------------------------------------------------------
  // Buffer write generation.
  // ---------------------------------------------------------------------------

  assign cur_count = count_q[core_idx];
  // Dropped silently while capture is disabled.
  assign wr_en     = char_pready & char_pwrite & slot_ok & cap_en;
  assign wr_addr   = {core_idx, cur_count[cnt_w-2:2]};
  assign wr_data   = {num_lanes{char_pwdata[7:0]}};

  always_comb begin
    wr_strb = '0;
    wr_strb[cur_count[1:0]] = 1'b1;
  end

  // ---------------------------------------------------------------------------
  // Per-core counters and wait flag.
  // ---------------------------------------------------------------------------

  always_ff @(posedge ref_clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < num_cores; i++) begin
        count_q[i] <= '0;
      end
    end else if (!cap_en || flush_pulse) begin
      for (int i = 0; i < num_cores; i++) begin
        count_q[i] <= '0;
      end
    end else if (wr_en) begin
      count_q[core_idx] <= cur_count + 1'b1;
    end
  end

  always_comb begin
    over_thr = 1'b0;
    for (int i = 0; i < num_cores; i++) begin
      if (count_q[i] >= threshold) begin
        over_thr = 1'b1;
      end
    end
  end

  always_ff @(posedge ref_clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_flag <= 1'b0;
    end else begin
      wait_flag <= over_thr;
    end
  end

  assign count0 = count_q[0];
  assign count1 = count_q[1];
  assign count2 = count_q[2];
  assign count3 = count_q[3];

endmodule

// File: source/stdout_pkg.sv
package stdout_pkg;

  // ---------------------------------------------------------------------------
  // Bus widths.
  // ---------------------------------------------------------------------------

  // Both APB ports share one address and data width.
  localparam int unsigned apb_addr_w = 12;
  localparam int unsigned apb_data_w = 32;

  // ---------------------------------------------------------------------------
  // Character bus layout.
  // ---------------------------------------------------------------------------

  localparam int unsigned num_cores  = 4;
  localparam int unsigned core_sel_w = 2;

  // Core slots sit at 0x00, 0x20, 0x40 and 0x60 of the low address byte.
  localparam logic [7:0] slot_stride = 8'h20;

  // ---------------------------------------------------------------------------
  // Host register map.
  // ---------------------------------------------------------------------------

  localparam logic [apb_addr_w-1:0] reg_ctrl        = 12'h000;
  localparam logic [apb_addr_w-1:0] reg_status      = 12'h004;
  // COUNT0 to COUNT3, one word apart.
  localparam logic [apb_addr_w-1:0] reg_count_base  = 12'h010;
  // Read window into the buffer, one word per buffer word.
  localparam logic [apb_addr_w-1:0] reg_window_base = 12'h100;

  // CTRL fields.
  localparam int unsigned ctrl_en_bit    = 0;
  localparam int unsigned ctrl_flush_bit = 1;

endpackage
